/* icache_config.svh */
// Instruction cache configuration
// Sizes and address field positions shared by the package, the RTL and the testbench
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

`define ICACHE_ADDR_W      32       // Fetch address width
`define ICACHE_DATA_W      128      // Fetch word and line width
`define ICACHE_NB_WAYS     4        // Associativity
`define ICACHE_WAY_W       2        // Way index width
`define ICACHE_SET_W       4        // Set index width
`define ICACHE_NB_SETS     16       // Sets per way
`define ICACHE_SET_LSB     4        // Bits 3:0 are the byte offset
`define ICACHE_TAG_W       7        // Stored tag, valid bit not included
`define ICACHE_TAG_LSB     8        // Tag is address bits 14:8

// Replacement LFSR start value, must not be zero
`define ICACHE_LFSR_SEED   8'h5a

`endif

/* icache_pkg.sv */
// Instruction cache types
// Controller states, store port bundles and refill port bundles
`include "icache_config.svh"

package icache_pkg;

   typedef enum logic [2:0]
   {
      DISABLED,
      FLUSH_ALL,
      FLUSH_SET,
      IDLE,
      LOOKUP,
      WAIT_REFILL
   } icache_state_e;

   typedef struct packed
   {
      logic                       valid;
      logic [`ICACHE_TAG_W-1:0]   tag;
   } tag_entry_t;

   typedef struct packed
   {
      logic [`ICACHE_NB_WAYS-1:0] req;     // One bit per way
      logic                       we;
      logic [`ICACHE_SET_W-1:0]   addr;
      tag_entry_t                 wdata;
   } tag_port_t;

   typedef struct packed
   {
      logic [`ICACHE_NB_WAYS-1:0] req;
      logic                       we;
      logic [`ICACHE_SET_W-1:0]   addr;
      logic [`ICACHE_DATA_W-1:0]  wdata;
   } data_port_t;

   typedef struct packed
   {
      logic                       req;     // Held until gnt
      logic [`ICACHE_ADDR_W-1:0]  addr;
   } refill_req_t;

   typedef struct packed
   {
      logic                       gnt;
      logic                       rvalid;
      logic [`ICACHE_DATA_W-1:0]  rdata;
   } refill_rsp_t;

endpackage

/* icache_tag_array.sv */
// Instruction cache tag store
// One bank per way, registered read, write on every requested way
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_tag_array
   import icache_pkg::*;
(
   input  logic                              clk,
   input  tag_port_t                         tag_i,
   output tag_entry_t [`ICACHE_NB_WAYS-1:0]  rdata_o
);

   for (genvar w = 0; w < `ICACHE_NB_WAYS; w++)
   begin : g_way
      tag_entry_t mem [`ICACHE_NB_SETS];

      always_ff @(posedge clk)
      begin
         if (tag_i.req[w])
         begin
            if (tag_i.we)
            begin
               mem[tag_i.addr] <= tag_i.wdata;
            end
            else
            begin
               rdata_o[w] <= mem[tag_i.addr];   // Valid one cycle later
            end
         end
      end
   end

endmodule

/* icache_data_array.sv */
// Instruction cache data store
// One 128-bit line per set and way, registered read
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_data_array
   import icache_pkg::*;
(
   input  logic                                              clk,
   input  data_port_t                                        data_i,
   output logic [`ICACHE_NB_WAYS-1:0][`ICACHE_DATA_W-1:0]    rdata_o
);

   for (genvar w = 0; w < `ICACHE_NB_WAYS; w++)
   begin : g_way
      logic [`ICACHE_DATA_W-1:0] mem [`ICACHE_NB_SETS];

      always_ff @(posedge clk)
      begin
         if (data_i.req[w])
         begin
            if (data_i.we)
            begin
               mem[data_i.addr] <= data_i.wdata;
            end
            else
            begin
               rdata_o[w] <= mem[data_i.addr];
            end
         end
      end
   end

endmodule

/* icache_way_select.sv */
// Instruction cache way selector
// Tag compare and hit encoding, victim choice with a replacement LFSR
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_way_select
   import icache_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  tag_entry_t [`ICACHE_NB_WAYS-1:0]  tags_i,
   input  logic [`ICACHE_ADDR_W-1:0]         lookup_addr_i,
   input  logic                              lfsr_step_i,
   output logic                              way_hit_o,
   output logic                              all_valid_o,
   output logic [`ICACHE_WAY_W-1:0]          hit_way_o,
   output logic [`ICACHE_NB_WAYS-1:0]        victim_way_o
);

   logic [`ICACHE_NB_WAYS-1:0] way_match;
   logic [`ICACHE_NB_WAYS-1:0] way_valid;
   logic [`ICACHE_TAG_W-1:0]   lookup_tag;
   logic [`ICACHE_WAY_W-1:0]   free_way;
   logic [7:0]                 lfsr_q;

   assign lookup_tag = lookup_addr_i[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];

   for (genvar w = 0; w < `ICACHE_NB_WAYS; w++)
   begin : g_cmp
      assign way_valid[w] = tags_i[w].valid;
      assign way_match[w] = tags_i[w].valid && (tags_i[w].tag == lookup_tag);
   end

   assign way_hit_o   = |way_match;
   assign all_valid_o = &way_valid;

   always_comb
   begin
      free_way  = '0;
      hit_way_o = '0;
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (!way_valid[w])
            free_way = w[`ICACHE_WAY_W-1:0];    // Highest invalid way wins
         if (way_match[w])
            hit_way_o = w[`ICACHE_WAY_W-1:0];
      end
      victim_way_o = '0;
      victim_way_o[all_valid_o ? lfsr_q[`ICACHE_WAY_W-1:0] : free_way] = 1'b1;
   end

   // Taps 8,6,5,4
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= `ICACHE_LFSR_SEED;
      else if (lfsr_step_i)
         lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
   end

endmodule

/* icache_bypass_tracker.sv */
// Instruction cache bypass tracker
// Registers the refill request of a bypassed fetch and flags it until its data returns
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_bypass_tracker
   import icache_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        bypass_i,
   input  logic                        fetch_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]   fetch_addr_i,
   input  logic                        fetch_gnt_i,
   input  refill_rsp_t                 refill_i,
   output logic                        bypass_busy_o,
   output refill_req_t                 bypass_refill_o
);

   logic bypass_fetch;   // Fetch accepted while bypassed

   assign bypass_fetch = bypass_i & fetch_req_i & fetch_gnt_i;

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         bypass_busy_o   <= 1'b0;
         bypass_refill_o <= '0;
      end
      else
      begin
         if (bypass_fetch)
            bypass_busy_o <= 1'b1;
         else if (refill_i.rvalid)
            bypass_busy_o <= 1'b0;    // Last outstanding fetch answered

         if (bypass_i | bypass_busy_o)
         begin
            if (bypass_fetch)
            begin
               bypass_refill_o.req  <= 1'b1;
               bypass_refill_o.addr <= fetch_addr_i;
            end
            else if (refill_i.gnt)
            begin
               bypass_refill_o.req <= 1'b0;
            end
         end
      end
   end

endmodule

/* icache_ctrl.sv */
// Instruction cache controller
// Lookup and single-beat refill, whole and per-set flush, bypass mode
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_ctrl
   import icache_pkg::*;
(
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  logic                                              bypass_i,
   input  logic                                              flush_i,
   input  logic                                              flush_set_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]                         flush_set_addr_i,
   input  logic                                              fetch_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]                         fetch_addr_i,
   input  logic                                              way_hit_i,
   input  logic                                              all_valid_i,
   input  logic [`ICACHE_WAY_W-1:0]                          hit_way_i,
   input  logic [`ICACHE_NB_WAYS-1:0]                        victim_way_i,
   input  logic [`ICACHE_NB_WAYS-1:0][`ICACHE_DATA_W-1:0]    data_rdata_i,
   input  logic                                              bypass_busy_i,
   input  refill_req_t                                       bypass_refill_i,
   input  refill_rsp_t                                       refill_i,
   output tag_port_t                                         tag_o,
   output data_port_t                                        data_o,
   output logic [`ICACHE_ADDR_W-1:0]                         lookup_addr_o,
   output logic                                              lfsr_step_o,
   output refill_req_t                                       refill_o,
   output logic                                              cache_is_bypassed_o,
   output logic                                              cache_is_flushed_o,
   output logic                                              flush_set_ack_o,
   output logic                                              fetch_gnt_o,
   output logic                                              fetch_rvalid_o,
   output logic [`ICACHE_DATA_W-1:0]                         fetch_rdata_o
);

   icache_state_e                state_q, state_d;
   logic [`ICACHE_ADDR_W-1:0]    lookup_addr_q;
   logic                         lookup_valid_q;
   logic [`ICACHE_NB_WAYS-1:0]   refill_way_q;
   logic [`ICACHE_SET_W-1:0]     flush_cnt_q, flush_cnt_d;
   logic                         hold_req;        // Bypass, flush or set flush pending
   logic                         grant;
   logic                         hit;
   logic                         lookup_done;
   logic                         save_way;

   assign hold_req      = bypass_i | flush_i | flush_set_req_i;
   assign hit           = lookup_valid_q & way_hit_i;
   assign lookup_addr_o = lookup_addr_q;

   ////////////////////
   // FSM
   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      grant               = 1'b0;
      lookup_done         = 1'b0;
      save_way            = 1'b0;
      lfsr_step_o         = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b0;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_i.rdata;
      refill_o.req        = 1'b0;
      refill_o.addr       = lookup_addr_q;

      tag_o.req           = '0;
      tag_o.we            = 1'b0;
      tag_o.addr          = fetch_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_W];
      tag_o.wdata.valid   = 1'b1;
      tag_o.wdata.tag     = lookup_addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
      data_o.req          = '0;
      data_o.we           = 1'b0;
      data_o.addr         = fetch_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_W];
      data_o.wdata        = refill_i.rdata;

      case (state_q)
         DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_set_ack_o     = 1'b1;
            fetch_gnt_o         = bypass_i & fetch_req_i;
            fetch_rvalid_o      = refill_i.rvalid;     // Single beat answer
            refill_o            = bypass_refill_i;
            flush_cnt_d         = '0;
            if (!bypass_i && !bypass_busy_i)
               state_d = FLUSH_ALL;
         end

         FLUSH_ALL:
         begin
            flush_set_ack_o = 1'b1;
            tag_o.req       = '1;
            tag_o.we        = 1'b1;
            tag_o.addr      = flush_cnt_q;
            tag_o.wdata     = '0;
            flush_cnt_d     = flush_cnt_q + 1'b1;      // Wraps to 0 on the last set
            if (flush_cnt_q == `ICACHE_SET_W'(`ICACHE_NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;
               state_d            = IDLE;
            end
         end

         FLUSH_SET:
         begin
            flush_set_ack_o = 1'b1;
            tag_o.req       = '1;
            tag_o.we        = 1'b1;
            tag_o.addr      = flush_set_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_W];
            tag_o.wdata     = '0;
            state_d         = IDLE;
         end

         IDLE:
         begin
            if (bypass_i)
               state_d = DISABLED;
            else if (flush_i)
               state_d = FLUSH_ALL;
            else if (flush_set_req_i)
               state_d = FLUSH_SET;
            else if (fetch_req_i)
            begin
               grant   = 1'b1;
               state_d = LOOKUP;
            end
         end

         LOOKUP:
         begin
            if (hit)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = data_rdata_i[hit_way_i];
               lookup_done    = 1'b1;
               grant          = fetch_req_i & ~hold_req;    // Next fetch only behind a hit
               state_d        = grant ? LOOKUP : IDLE;
            end
            else
            begin
               refill_o.req = 1'b1;
               if (refill_i.gnt)
               begin
                  save_way    = 1'b1;
                  lfsr_step_o = all_valid_i;   // Full set, random victim consumed
                  state_d     = WAIT_REFILL;
               end
            end
         end

         WAIT_REFILL:
         begin
            fetch_rvalid_o = refill_i.rvalid;
            tag_o.req      = refill_way_q & {`ICACHE_NB_WAYS{refill_i.rvalid}};
            tag_o.we       = 1'b1;
            tag_o.addr     = lookup_addr_q[`ICACHE_SET_LSB +: `ICACHE_SET_W];
            data_o.req     = refill_way_q & {`ICACHE_NB_WAYS{refill_i.rvalid}};
            data_o.we      = 1'b1;
            data_o.addr    = lookup_addr_q[`ICACHE_SET_LSB +: `ICACHE_SET_W];
            if (refill_i.rvalid)
            begin
               lookup_done = 1'b1;
               state_d     = IDLE;
            end
         end

         default: state_d = DISABLED;
      endcase

      // Granted fetch reads both stores in the same cycle
      if (grant)
      begin
         fetch_gnt_o = 1'b1;
         tag_o.req   = '1;
         data_o.req  = '1;
      end
   end

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q        <= DISABLED;
         flush_cnt_q    <= '0;
         lookup_valid_q <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         if (grant)
            lookup_valid_q <= 1'b1;
         else if (lookup_done)
            lookup_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (grant)
         lookup_addr_q <= fetch_addr_i;
      if (save_way)
         refill_way_q <= victim_way_i;    // Way that takes the refilled line
   end

endmodule

/* pri_icache.sv */
// Private instruction cache top level
// 4-way set-associative, 128-bit fetch port, single-beat refill port
`timescale 1ns/10ps
`include "icache_config.svh"

module pri_icache
   import icache_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        bypass_i,
   input  logic                        flush_i,
   input  logic                        flush_set_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]   flush_set_addr_i,
   input  logic                        fetch_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]   fetch_addr_i,
   output logic                        cache_is_bypassed_o,
   output logic                        cache_is_flushed_o,
   output logic                        flush_set_ack_o,
   output logic                        fetch_gnt_o,
   output logic                        fetch_rvalid_o,
   output logic [`ICACHE_DATA_W-1:0]   fetch_rdata_o,
   output refill_req_t                 refill_o,
   input  refill_rsp_t                 refill_i
);

   tag_port_t                                          tag_port;
   data_port_t                                         data_port;
   tag_entry_t [`ICACHE_NB_WAYS-1:0]                   tag_rdata;
   logic [`ICACHE_NB_WAYS-1:0][`ICACHE_DATA_W-1:0]     data_rdata;
   logic [`ICACHE_ADDR_W-1:0]                          lookup_addr;
   logic                                               lfsr_step;
   logic                                               way_hit;
   logic                                               all_valid;
   logic [`ICACHE_WAY_W-1:0]                           hit_way;
   logic [`ICACHE_NB_WAYS-1:0]                         victim_way;
   logic                                               bypass_busy;
   refill_req_t                                        bypass_refill;

   icache_ctrl i_ctrl
   (
      .clk                 ( clk                 ),
      .rst_n               ( rst_n               ),
      .bypass_i            ( bypass_i            ),
      .flush_i             ( flush_i             ),
      .flush_set_req_i     ( flush_set_req_i     ),
      .flush_set_addr_i    ( flush_set_addr_i    ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .way_hit_i           ( way_hit             ),
      .all_valid_i         ( all_valid           ),
      .hit_way_i           ( hit_way             ),
      .victim_way_i        ( victim_way          ),
      .data_rdata_i        ( data_rdata          ),
      .bypass_busy_i       ( bypass_busy         ),
      .bypass_refill_i     ( bypass_refill       ),
      .refill_i            ( refill_i            ),
      .tag_o               ( tag_port            ),
      .data_o              ( data_port           ),
      .lookup_addr_o       ( lookup_addr         ),
      .lfsr_step_o         ( lfsr_step           ),
      .refill_o            ( refill_o            ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .flush_set_ack_o     ( flush_set_ack_o     ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       )
   );

   icache_tag_array i_tag_array
   (
      .clk     ( clk       ),
      .tag_i   ( tag_port  ),
      .rdata_o ( tag_rdata )
   );

   icache_data_array i_data_array
   (
      .clk     ( clk        ),
      .data_i  ( data_port  ),
      .rdata_o ( data_rdata )
   );

   icache_way_select i_way_select
   (
      .clk           ( clk         ),
      .rst_n         ( rst_n       ),
      .tags_i        ( tag_rdata   ),
      .lookup_addr_i ( lookup_addr ),
      .lfsr_step_i   ( lfsr_step   ),
      .way_hit_o     ( way_hit     ),
      .all_valid_o   ( all_valid   ),
      .hit_way_o     ( hit_way     ),
      .victim_way_o  ( victim_way  )
   );

   icache_bypass_tracker i_bypass_tracker
   (
      .clk             ( clk           ),
      .rst_n           ( rst_n         ),
      .bypass_i        ( bypass_i      ),
      .fetch_req_i     ( fetch_req_i   ),
      .fetch_addr_i    ( fetch_addr_i  ),
      .fetch_gnt_i     ( fetch_gnt_o   ),
      .refill_i        ( refill_i      ),
      .bypass_busy_o   ( bypass_busy   ),
      .bypass_refill_o ( bypass_refill )
   );

endmodule

/* tb_refill_mem.sv */
// Refill memory model for the instruction cache testbench
// Grants each request after a random delay and answers with an address-derived line
`timescale 1ns/10ps
`include "icache_config.svh"

module tb_refill_mem
   import icache_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  refill_req_t   req_i,
   output refill_rsp_t   rsp_o,
   output logic [31:0]   req_count_o
);

   localparam logic [`ICACHE_DATA_W-1:0] LINE_MASK =
      128'hc3a5_5a3c_0f1e_2d4b_9687_7869_f0e1_d2c3;

   integer                      seed = 32'ha951_3feb;
   integer                      wait_cnt;     // -1 while no request is being delayed
   integer                      resp_cnt;     // Cycles left until the answer
   logic [`ICACHE_ADDR_W-1:0]   line_addr;

   // Outputs change on the falling edge, the cache samples them on the rising edge
   always @(negedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         rsp_o       <= '0;
         req_count_o <= '0;
         wait_cnt     = -1;
         resp_cnt     = 0;
         line_addr    = '0;
      end
      else
      begin
         rsp_o.gnt    <= 1'b0;
         rsp_o.rvalid <= 1'b0;

         if (resp_cnt == 1)
         begin
            rsp_o.rvalid <= 1'b1;
            rsp_o.rdata  <= {4{{4'h0, line_addr[31:4]}}} ^ LINE_MASK;
         end
         if (resp_cnt > 0)
            resp_cnt = resp_cnt - 1;

         // New request, the old grant value is still visible here
         if (req_i.req && !rsp_o.gnt && resp_cnt == 0)
         begin
            if (wait_cnt < 0)
               wait_cnt = $unsigned($random(seed)) % 4;
            if (wait_cnt == 0)
            begin
               rsp_o.gnt   <= 1'b1;
               req_count_o <= req_count_o + 1;
               line_addr    = req_i.addr;
               resp_cnt     = 2;       // Line two cycles after the grant
               wait_cnt     = -1;
            end
            else
            begin
               wait_cnt = wait_cnt - 1;
            end
         end
      end
   end

endmodule

/* tb_pri_icache.sv */
// Testbench for the private instruction cache
// Bypass, miss and hit, eviction, set flush and whole flush, checked by assertions
`timescale 1ns/10ps
`include "icache_config.svh"

module tb_pri_icache
   import icache_pkg::*;
();

   localparam int WAIT_LIMIT = 60;
   localparam logic [`ICACHE_DATA_W-1:0] LINE_MASK =
      128'hc3a5_5a3c_0f1e_2d4b_9687_7869_f0e1_d2c3;
   localparam logic [`ICACHE_ADDR_W-1:0] ADDR_A = 32'h0000_0310;   // Tag 3, set 1
   localparam logic [`ICACHE_ADDR_W-1:0] ADDR_B = 32'h0000_0420;   // Tag 4, set 2

   logic                        clk;
   logic                        rst_n;
   logic                        bypass_i;
   logic                        flush_i;
   logic                        flush_set_req_i;
   logic [`ICACHE_ADDR_W-1:0]   flush_set_addr_i;
   logic                        fetch_req_i;
   logic [`ICACHE_ADDR_W-1:0]   fetch_addr_i;
   logic                        cache_is_bypassed_o;
   logic                        cache_is_flushed_o;
   logic                        flush_set_ack_o;
   logic                        fetch_gnt_o;
   logic                        fetch_rvalid_o;
   logic [`ICACHE_DATA_W-1:0]   fetch_rdata_o;
   refill_req_t                 refill_o;
   refill_rsp_t                 refill_i;
   logic [31:0]                 refill_count;

   logic                        expect_hit;
   logic [`ICACHE_DATA_W-1:0]   exp_q [$];       // Lines of granted fetches, oldest first
   logic [`ICACHE_DATA_W-1:0]   exp_head = '0;
   int                          exp_count = 0;
   int                          fetch_count = 0;
   int                          error_count = 0;

   pri_icache i_dut
   (
      .clk                 ( clk                 ),
      .rst_n               ( rst_n               ),
      .bypass_i            ( bypass_i            ),
      .flush_i             ( flush_i             ),
      .flush_set_req_i     ( flush_set_req_i     ),
      .flush_set_addr_i    ( flush_set_addr_i    ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .flush_set_ack_o     ( flush_set_ack_o     ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_o            ( refill_o            ),
      .refill_i            ( refill_i            )
   );

   tb_refill_mem i_refill_mem
   (
      .clk         ( clk          ),
      .rst_n       ( rst_n        ),
      .req_i       ( refill_o     ),
      .rsp_o       ( refill_i     ),
      .req_count_o ( refill_count )
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Line the refill port returns for an address
   function automatic logic [`ICACHE_DATA_W-1:0] expected_line(input logic [31:0] addr);
      logic [31:0] word;
      word = {4'h0, addr[31:4]};
      return {4{word}} ^ LINE_MASK;
   endfunction

   // Set 9 with tag k
   function automatic logic [31:0] same_set_addr(input int k);
      return 32'h0000_0090 | (32'(k) << 8);
   endfunction

   task automatic record_failure(input string msg);
      error_count++;
      $display("FAILED %0t: %s", $time, msg);
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0t while waiting for %s", $time, what);
      $display("TB FAILED");
      $finish;
   endtask

   ////////////////////
   // Scoreboard
   always @(posedge clk)
   begin
      if (fetch_rvalid_o && exp_q.size() != 0)
         void'(exp_q.pop_front());
      if (fetch_req_i && fetch_gnt_o)
      begin
         exp_q.push_back(expected_line(fetch_addr_i));
         fetch_count++;
      end
      exp_count = exp_q.size();
      exp_head  = (exp_count != 0) ? exp_q[0] : '0;
   end

   ////////////////////
   // Assertions
   a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_o |-> (exp_count != 0) && (fetch_rdata_o == exp_head))
   else
      record_failure("fetch response unrequested or its line differs from the model");

   a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_req_i && fetch_gnt_o && expect_hit |=> fetch_rvalid_o && !refill_o.req)
   else
      record_failure("cached fetch not answered one cycle after its grant");

   a_hold_no_gnt: assert property (@(posedge clk) disable iff (!rst_n)
      (flush_i || flush_set_req_i || bypass_i) && !cache_is_bypassed_o |-> !fetch_gnt_o)
   else
      record_failure("fetch granted while a flush or bypass request is pending");

   a_refill_held: assert property (@(posedge clk) disable iff (!rst_n)
      refill_o.req && !refill_i.gnt |=> refill_o.req && $stable(refill_o.addr))
   else
      record_failure("refill request dropped or changed before its grant");

   a_disabled_status: assert property (@(posedge clk) disable iff (!rst_n)
      cache_is_bypassed_o |-> cache_is_flushed_o && flush_set_ack_o)
   else
      record_failure("status outputs wrong while bypassed");

   ////////////////////
   // Stimulus tasks
   task automatic issue_fetch(input logic [31:0] addr, input logic hit);
      int cycles;
      cycles = 0;
      @(negedge clk);
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      expect_hit   = hit;
      #1;
      while (!fetch_gnt_o && cycles < WAIT_LIMIT)
      begin
         cycles++;
         @(negedge clk);
         #1;
      end
      if (!fetch_gnt_o)
         report_timeout("a fetch grant");
      @(posedge clk);                        // Edge that accepts the fetch
   endtask

   task automatic drain_responses();
      int cycles;
      cycles = 0;
      @(negedge clk);
      fetch_req_i = 1'b0;
      expect_hit  = 1'b0;
      #1;
      while (exp_count != 0 && cycles < WAIT_LIMIT)
      begin
         cycles++;
         @(negedge clk);
         #1;
      end
      if (exp_count != 0)
         report_timeout("outstanding fetch responses");
   endtask

   // A negative refill count skips the count check
   task automatic fetch_one(input logic [31:0] addr, input logic hit, input int refills);
      int start;
      start = refill_count;
      issue_fetch(addr, hit);
      drain_responses();
      if (refills >= 0)
         assert (refill_count - start == refills)
         else
            record_failure($sformatf("fetch of %h caused %0d refills, expected %0d",
                                     addr, refill_count - start, refills));
   endtask

   // Request held for one cycle together with a fetch that must not be granted
   task automatic raise_with_fetch(input logic fl, input logic fl_set, input logic byp,
                                   input logic [31:0] addr);
      @(negedge clk);
      flush_i          = fl;
      flush_set_req_i  = fl_set;
      bypass_i         = byp;
      flush_set_addr_i = addr;
      fetch_req_i      = 1'b1;
      fetch_addr_i     = addr;
      #1;
      assert (!fetch_gnt_o)
      else
         record_failure("fetch granted in IDLE beside a flush or bypass request");
      @(negedge clk);
      flush_i         = 1'b0;
      flush_set_req_i = 1'b0;
      bypass_i        = 1'b0;
      fetch_req_i     = 1'b0;
   endtask

   task automatic check_flush_length();
      int  flush_cycles;
      int  cycles;
      logic done;
      flush_cycles = 0;
      cycles       = 0;
      done         = 1'b0;
      #1;
      while (!done && cycles < WAIT_LIMIT)
      begin
         if (flush_set_ack_o && !cache_is_bypassed_o)
            flush_cycles++;
         done = !cache_is_bypassed_o && cache_is_flushed_o;
         if (!done)
         begin
            cycles++;
            @(negedge clk);
            #1;
         end
      end
      if (!done)
         report_timeout("the end of the whole cache flush");
      assert (flush_cycles == `ICACHE_NB_SETS)
      else
         record_failure($sformatf("whole flush took %0d cycles", flush_cycles));
      @(negedge clk);
      #1;
      assert (!cache_is_flushed_o && !flush_set_ack_o)
      else
         record_failure("cache not back in IDLE after the whole flush");
   endtask

   ////////////////////
   // Test sequence
   initial
   begin
      int start;
      rst_n            = 1'b0;
      bypass_i         = 1'b1;
      flush_i          = 1'b0;
      flush_set_req_i  = 1'b0;
      flush_set_addr_i = '0;
      fetch_req_i      = 1'b0;
      fetch_addr_i     = '0;
      expect_hit       = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      #1;
      assert (cache_is_bypassed_o && cache_is_flushed_o && !refill_o.req && !fetch_rvalid_o)
      else
         record_failure("status wrong after reset");

      // Bypassed fetches, one refill each
      fetch_one(32'h0000_1230, 1'b0, 1);
      fetch_one(32'h0001_0040, 1'b0, 1);
      fetch_one(32'h8000_0ff0, 1'b0, 1);
      fetch_one(ADDR_A, 1'b0, 1);

      @(negedge clk);
      bypass_i = 1'b0;
      check_flush_length();

      // Miss, then hit without refill
      fetch_one(ADDR_A, 1'b0, 1);
      fetch_one(ADDR_A, 1'b1, 0);
      fetch_one(ADDR_B, 1'b0, 1);

      start = refill_count;
      issue_fetch(ADDR_A, 1'b1);    // Back-to-back hits
      issue_fetch(ADDR_B, 1'b1);
      issue_fetch(ADDR_A, 1'b1);
      drain_responses();
      assert (refill_count == start)
      else
         record_failure("streamed hits caused a refill");

      // Five tags in one 4-way set
      for (int k = 1; k <= 5; k++)
         fetch_one(same_set_addr(k), 1'b0, 1);
      fetch_one(same_set_addr(5), 1'b1, 0);
      start = refill_count;
      for (int k = 1; k <= 4; k++)
         fetch_one(same_set_addr(k), 1'b0, -1);
      assert (refill_count - start >= 1 && refill_count - start <= 4)
      else
         record_failure($sformatf("%0d refills for four tags after an eviction",
                                  refill_count - start));

      // Set flush of B's set only
      raise_with_fetch(1'b0, 1'b1, 1'b0, ADDR_B);
      #1;
      assert (flush_set_ack_o && !cache_is_flushed_o)
      else
         record_failure("set flush not acknowledged");
      fetch_one(ADDR_B, 1'b0, 1);
      fetch_one(ADDR_A, 1'b1, 0);

      // Whole flush, everything refills
      raise_with_fetch(1'b1, 1'b0, 1'b0, ADDR_A);
      check_flush_length();
      fetch_one(ADDR_A, 1'b0, 1);
      fetch_one(ADDR_B, 1'b0, 1);
      fetch_one(same_set_addr(5), 1'b0, 1);

      // Bypass request from IDLE, back through DISABLED and a whole flush
      raise_with_fetch(1'b0, 1'b0, 1'b1, ADDR_A);
      check_flush_length();
      fetch_one(ADDR_A, 1'b0, 1);

      $display("Fetches %0d, refills %0d, errors %0d", fetch_count, refill_count, error_count);
      if (error_count == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

/* sources.f */
+incdir+.
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_way_select.sv
icache_bypass_tracker.sv
icache_ctrl.sv
pri_icache.sv
tb_refill_mem.sv
tb_pri_icache.sv
